// File: Makefile
VERILATOR ?= verilator
TOP       := pipeCpuTb
FILELIST  := pipeCpu.f
BUILD_DIR := obj_dir
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# The simulator exits nonzero on $fatal, so make fails with it
sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: design/cpuPkg.sv
`default_nettype none

package cpuPkg;

  typedef logic [13:0] wordT;
  typedef logic [4:0] regIdxT;
  typedef logic [3:0] flagsT;

  // Instruction bits 13 to 10, unlisted codes run as no-op
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SUB  = 4'b0001,
    ADDC = 4'b0010,
    SUBC = 4'b0011,
    NOT  = 4'b0100,
    AND  = 4'b0101,
    OR   = 4'b0110,
    SHRA = 4'b0111,
    ST   = 4'b1001,
    LD   = 4'b1010,
    JMP  = 4'b1011,
    CPY  = 4'b1100
  } opcodeT;

  // Jump condition in bits 4 to 1
  typedef enum logic [3:0] {
    JU  = 4'b0000,
    JC1 = 4'b1000,
    JN1 = 4'b0100,
    JV1 = 4'b0010,
    JZ1 = 4'b0001,
    JC0 = 4'b0111,
    JN0 = 4'b1011,
    JV0 = 4'b1101,
    JZ0 = 4'b1110
  } jumpCondT;

  localparam int flagC = 3;
  localparam int flagN = 2;
  localparam int flagV = 1;
  localparam int flagZ = 0;

  // Window bounds are exclusive
  localparam wordT ioLow = 14'h3F00;
  localparam wordT ioHigh = 14'h3FFF;

  localparam wordT nopWord = 14'h3FFF;

endpackage

`default_nettype wire

// File: design/executeStage.sv
`default_nettype none
`timescale 1ns/100ps

module executeStage (
  input logic Clock_pin,
  input logic rst,
  input logic opValid,
  input cpuPkg::wordT opInstr,
  input cpuPkg::wordT opA,
  input cpuPkg::wordT opB,
  input cpuPkg::wordT memAddr,
  input cpuPkg::regIdxT destIdx,
  input logic [4:0] sw,
  output logic wrEn,
  output cpuPkg::regIdxT wrIdx,
  output cpuPkg::wordT wrData,
  output logic wbValid,
  output cpuPkg::regIdxT wbIdx,
  output cpuPkg::wordT wbData,
  output logic jumpTaken,
  output cpuPkg::wordT jumpTarget,
  output logic retire,
  output logic [7:0] display,
  output logic displayWrite
);

  cpuPkg::opcodeT op;
  cpuPkg::jumpCondT cond;
  cpuPkg::flagsT flags;
  cpuPkg::flagsT nextFlags;
  logic isSub;
  logic [14:0] sum;
  logic ovf;
  logic inWindow;
  logic condMet;
  logic writes;
  cpuPkg::wordT res;

  assign op = cpuPkg::opcodeT'(opInstr[13:10]);
  assign cond = cpuPkg::jumpCondT'(opInstr[4:1]);

  assign isSub = (op == cpuPkg::SUB) || (op == cpuPkg::SUBC);
  assign sum = isSub ? ({1'b0, opA} - {1'b0, opB}) : ({1'b0, opA} + {1'b0, opB});
  // Signed overflow, subtract flips the sign test on B
  assign ovf = ((opA[13] ^ opB[13]) == isSub) && (sum[13] != opA[13]);

  assign inWindow = (memAddr > cpuPkg::ioLow) && (memAddr < cpuPkg::ioHigh);

  always_comb
  begin
    res = '0;
    writes = 1'b0;
    nextFlags = flags;
    case (op)
      cpuPkg::ADD, cpuPkg::SUB, cpuPkg::ADDC, cpuPkg::SUBC:
      begin
        res = sum[13:0];
        writes = 1'b1;
        nextFlags[cpuPkg::flagC] = sum[14];
        nextFlags[cpuPkg::flagN] = sum[13];
        nextFlags[cpuPkg::flagV] = ovf;
        nextFlags[cpuPkg::flagZ] = (sum[13:0] == '0);
      end
      cpuPkg::NOT:
      begin
        res = ~opA;
        writes = 1'b1;
      end
      cpuPkg::AND, cpuPkg::OR:
      begin
        res = (op == cpuPkg::AND) ? (opA & opB) : (opA | opB);
        writes = 1'b1;
        nextFlags[cpuPkg::flagN] = res[13];
        nextFlags[cpuPkg::flagZ] = (res == '0);
      end
      cpuPkg::SHRA:
      begin
        res = cpuPkg::wordT'($signed(opA) >>> opInstr[1:0]);
        writes = 1'b1;
      end
      cpuPkg::CPY:
      begin
        res = opB;
        writes = 1'b1;
      end
      cpuPkg::LD:
      begin
        // No data RAM behind the window
        res = inWindow ? {9'b0, sw} : '0;
        writes = 1'b1;
      end
      default:
      begin
        res = '0;
      end
    endcase
  end

  always_comb
  begin
    case (cond)
      cpuPkg::JU:  condMet = 1'b1;
      cpuPkg::JC1: condMet = flags[cpuPkg::flagC];
      cpuPkg::JN1: condMet = flags[cpuPkg::flagN];
      cpuPkg::JV1: condMet = flags[cpuPkg::flagV];
      cpuPkg::JZ1: condMet = flags[cpuPkg::flagZ];
      cpuPkg::JC0: condMet = !flags[cpuPkg::flagC];
      cpuPkg::JN0: condMet = !flags[cpuPkg::flagN];
      cpuPkg::JV0: condMet = !flags[cpuPkg::flagV];
      cpuPkg::JZ0: condMet = !flags[cpuPkg::flagZ];
      default:     condMet = 1'b0;
    endcase
  end

  assign wrEn = opValid && writes;
  assign wrIdx = destIdx;
  assign wrData = res;
  assign wbValid = wrEn;
  assign wbIdx = destIdx;
  assign wbData = res;

  assign jumpTaken = opValid && (op == cpuPkg::JMP) && condMet;
  assign jumpTarget = memAddr;
  assign retire = opValid && (op == cpuPkg::LD || op == cpuPkg::ST || op == cpuPkg::JMP);

  always_ff @(posedge Clock_pin)
  begin
    if (rst)
    begin
      flags <= '0;
      display <= '0;
      displayWrite <= 1'b0;
    end
    else
    begin
      displayWrite <= 1'b0;
      if (opValid)
        flags <= nextFlags;
      if (opValid && op == cpuPkg::ST && inWindow)
      begin
        display <= opB[7:0];
        displayWrite <= 1'b1;
      end
    end
  end

  // Fetch stall keeps stores apart so each write is a single pulse
  displayFromStore: assert property (@(posedge Clock_pin) disable iff (rst)
    displayWrite |-> $past(opValid && op == cpuPkg::ST) ##1 !displayWrite);

  // Fetch stall leaves nothing behind a jump
  jumpOnlyJmp: assert property (@(posedge Clock_pin) disable iff (rst)
    jumpTaken |-> (op == cpuPkg::JMP) ##1 !opValid);

endmodule

`default_nettype wire

// File: design/fetchUnit.sv
`default_nettype none
`timescale 1ns/100ps

module fetchUnit #(
  parameter int progAddrW = 10
) (
  input logic Clock_pin,
  input logic rst,
  input cpuPkg::wordT romData,
  input logic jumpTaken,
  input cpuPkg::wordT jumpTarget,
  input logic retire,
  output logic [progAddrW-1:0] romAddr,
  output logic issueValid,
  output cpuPkg::wordT issueInstr,
  output cpuPkg::wordT addrWord
);

  typedef enum logic [1:0] {
    RUN,
    ADDRWORD,
    WAIT
  } stateT;

  stateT state;
  logic [progAddrW-1:0] pc;
  // romData holds a word from the current fetch stream
  logic wordValid;
  cpuPkg::opcodeT romOp;
  logic needsAddr;

  assign romAddr = pc;
  assign romOp = cpuPkg::opcodeT'(romData[13:10]);
  assign needsAddr = (romOp == cpuPkg::LD) || (romOp == cpuPkg::ST) || (romOp == cpuPkg::JMP);

  always_ff @(posedge Clock_pin)
  begin
    if (rst)
    begin
      pc <= '0;
      state <= RUN;
      wordValid <= 1'b0;
      issueValid <= 1'b0;
    end
    else
    begin
      issueValid <= 1'b0;
      case (state)
        RUN:
        begin
          pc <= pc + 1'b1;
          wordValid <= 1'b1;
          if (wordValid)
          begin
            if (needsAddr)
              state <= ADDRWORD;
            else
              issueValid <= 1'b1;
          end
        end
        ADDRWORD:
        begin
          // Address word is on romData, hold pc at the next opcode
          issueValid <= 1'b1;
          state <= WAIT;
        end
        WAIT:
        begin
          if (retire)
          begin
            wordValid <= 1'b0;
            state <= RUN;
            if (jumpTaken)
              pc <= jumpTarget[progAddrW-1:0];
          end
        end
        default:
          state <= RUN;
      endcase
    end
  end

  always_ff @(posedge Clock_pin)
  begin
    if (state == RUN && wordValid)
      issueInstr <= romData;
    if (state == ADDRWORD)
      addrWord <= romData;
  end

  // Stalled fetch only moves on a taken jump
  pcHoldInWait: assert property (@(posedge Clock_pin) disable iff (rst)
    (state == WAIT && !jumpTaken) |=> $stable(pc));

endmodule

`default_nettype wire

// File: design/operandStage.sv
`default_nettype none
`timescale 1ns/100ps

module operandStage (
  input logic Clock_pin,
  input logic rst,
  input logic issueValid,
  input cpuPkg::wordT issueInstr,
  input cpuPkg::wordT addrWord,
  output cpuPkg::regIdxT rdIdxA,
  output cpuPkg::regIdxT rdIdxB,
  input cpuPkg::wordT rdA,
  input cpuPkg::wordT rdB,
  input logic wbValid,
  input cpuPkg::regIdxT wbIdx,
  input cpuPkg::wordT wbData,
  output logic opValid,
  output cpuPkg::wordT opInstr,
  output cpuPkg::wordT opA,
  output cpuPkg::wordT opB,
  output cpuPkg::wordT memAddr,
  output cpuPkg::regIdxT destIdx
);

  cpuPkg::opcodeT op;
  cpuPkg::wordT fwdA;
  cpuPkg::wordT fwdB;
  cpuPkg::wordT nextB;
  cpuPkg::wordT indexVal;

  assign op = cpuPkg::opcodeT'(issueInstr[13:10]);
  assign rdIdxA = issueInstr[9:5];
  assign rdIdxB = issueInstr[4:0];

  // Bypass from the instruction in execute
  assign fwdA = (wbValid && wbIdx == rdIdxA) ? wbData : rdA;
  assign fwdB = (wbValid && wbIdx == rdIdxB) ? wbData : rdB;

  always_comb
  begin
    case (op)
      cpuPkg::ADDC, cpuPkg::SUBC:
        nextB = {9'b0, issueInstr[4:0]};
      default:
        nextB = fwdB;
    endcase
  end

  // R0 as index means no index
  assign indexVal = (rdIdxA == '0) ? '0 : fwdA;

  always_ff @(posedge Clock_pin)
  begin
    if (rst)
      opValid <= 1'b0;
    else
      opValid <= issueValid;
  end

  always_ff @(posedge Clock_pin)
  begin
    opInstr <= issueValid ? issueInstr : cpuPkg::nopWord;
    if (issueValid)
    begin
      opA <= fwdA;
      opB <= nextB;
      memAddr <= addrWord + indexVal;
      // LD loads into Rj, the rest target Ri
      destIdx <= (op == cpuPkg::LD) ? rdIdxB : rdIdxA;
    end
  end

endmodule

`default_nettype wire

// File: design/pipeCpu.sv
`default_nettype none
`timescale 1ns/100ps

module pipeCpu #(
  parameter int progAddrW = 10
) (
  input logic Clock_pin,
  input logic rst,
  input logic [4:0] sw,
  output logic [7:0] display,
  output logic displayWrite
);

  logic [progAddrW-1:0] romAddr;
  cpuPkg::wordT romData;
  logic issueValid;
  cpuPkg::wordT issueInstr;
  cpuPkg::wordT addrWord;
  cpuPkg::regIdxT rdIdxA;
  cpuPkg::regIdxT rdIdxB;
  cpuPkg::wordT rdA;
  cpuPkg::wordT rdB;
  logic wrEn;
  cpuPkg::regIdxT wrIdx;
  cpuPkg::wordT wrData;
  logic wbValid;
  cpuPkg::regIdxT wbIdx;
  cpuPkg::wordT wbData;
  logic opValid;
  cpuPkg::wordT opInstr;
  cpuPkg::wordT opA;
  cpuPkg::wordT opB;
  cpuPkg::wordT memAddr;
  cpuPkg::regIdxT destIdx;
  logic jumpTaken;
  cpuPkg::wordT jumpTarget;
  logic retire;

  progRom #(.progAddrW(progAddrW)) rom (.Clock_pin, .romAddr, .romData);

  fetchUnit #(.progAddrW(progAddrW)) fetch (
    .Clock_pin, .rst, .romData, .jumpTaken, .jumpTarget, .retire,
    .romAddr, .issueValid, .issueInstr, .addrWord
  );

  regFile regs (.Clock_pin, .rst, .rdIdxA, .rdIdxB, .rdA, .rdB, .wrEn, .wrIdx, .wrData);

  operandStage operands (
    .Clock_pin, .rst, .issueValid, .issueInstr, .addrWord, .rdIdxA, .rdIdxB,
    .rdA, .rdB, .wbValid, .wbIdx, .wbData, .opValid, .opInstr, .opA, .opB,
    .memAddr, .destIdx
  );

  executeStage execute (
    .Clock_pin, .rst, .opValid, .opInstr, .opA, .opB, .memAddr, .destIdx, .sw,
    .wrEn, .wrIdx, .wrData, .wbValid, .wbIdx, .wbData, .jumpTaken, .jumpTarget,
    .retire, .display, .displayWrite
  );

endmodule

`default_nettype wire

// File: design/progRom.sv
`default_nettype none
`timescale 1ns/100ps

module progRom #(
  parameter int progAddrW = 10
) (
  input logic Clock_pin,
  input logic [progAddrW-1:0] romAddr,
  output cpuPkg::wordT romData
);

  cpuPkg::wordT mem [2**progAddrW];

  // Program image is written in after this
  initial
  begin
    for (int i = 0; i < 2**progAddrW; i++)
    begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge Clock_pin)
  begin
    romData <= mem[romAddr];
  end

endmodule

`default_nettype wire

// File: design/regFile.sv
`default_nettype none
`timescale 1ns/100ps

module regFile (
  input logic Clock_pin,
  input logic rst,
  input cpuPkg::regIdxT rdIdxA,
  input cpuPkg::regIdxT rdIdxB,
  output cpuPkg::wordT rdA,
  output cpuPkg::wordT rdB,
  input logic wrEn,
  input cpuPkg::regIdxT wrIdx,
  input cpuPkg::wordT wrData
);

  cpuPkg::wordT regs [32];

  always_ff @(posedge Clock_pin)
  begin
    if (rst)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wrEn)
    begin
      regs[wrIdx] <= wrData;
    end
  end

  // Same cycle write shows up on the read ports
  assign rdA = (wrEn && wrIdx == rdIdxA) ? wrData : regs[rdIdxA];
  assign rdB = (wrEn && wrIdx == rdIdxB) ? wrData : regs[rdIdxB];

endmodule

`default_nettype wire

// File: dv/cpuTests.svh
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

// Inside the I/O window
localparam int ioIn = 'h3F01;

function automatic cpuPkg::wordT encode(input cpuPkg::opcodeT op, input int ri,
                                        input int rj);
  return {op, ri[4:0], rj[4:0]};
endfunction

task automatic newProgram();
  prog.delete();
  expected.delete();
endtask

task automatic addOp(input cpuPkg::opcodeT op, input int ri, input int rj);
  prog.push_back(encode(op, ri, rj));
endtask

// Opcode word followed by its address word
task automatic memOp(input cpuPkg::opcodeT op, input int ri, input int rj, input int addr);
  prog.push_back(encode(op, ri, rj));
  prog.push_back(addr[13:0]);
endtask

// Taken path stores R1, fall-through stores R2
task automatic condBlock(input cpuPkg::jumpCondT cond, input logic taken);
  int base;
  base = prog.size();
  prog.push_back({cpuPkg::JMP, 5'd0, cond, 1'b0});
  prog.push_back(14'(base + 6));
  memOp(cpuPkg::ST, 0, 2, ioIn);
  prog.push_back({cpuPkg::JMP, 5'd0, cpuPkg::JU, 1'b0});
  prog.push_back(14'(base + 8));
  memOp(cpuPkg::ST, 0, 1, ioIn);
  expected.push_back(taken ? 8'd1 : 8'd2);
endtask

// ROM is written while reset is held
task automatic loadProgram(input logic [4:0] swVal);
  int a;
  @(posedge Clock_pin);
  #2;
  rst = 1'b1;
  sw = swVal;
  seen.delete();
  for (a = 0; a < romWords; a++)
    DUT.rom.mem[a] = (a < prog.size()) ? prog[a] : '0;
  repeat (resetCycles) @(posedge Clock_pin);
  #2;
  rst = 1'b0;
endtask

task automatic arithmeticTest();
  int a, c1, c2;
  cpuPkg::wordT vb, vc, vd, ve;
  a = $random(seed) & 31;
  c1 = $random(seed) & 31;
  c2 = $random(seed) & 31;
  vb = 14'(a + c1);
  vc = 14'(a - c2);
  vd = vb + vc;
  ve = vc - vd;
  newProgram();
  memOp(cpuPkg::LD, 0, 1, ioIn);
  addOp(cpuPkg::CPY, 2, 1);
  addOp(cpuPkg::ADDC, 2, c1);
  memOp(cpuPkg::ST, 0, 2, ioIn);
  addOp(cpuPkg::CPY, 3, 1);
  addOp(cpuPkg::SUBC, 3, c2);
  memOp(cpuPkg::ST, 0, 3, ioIn);
  addOp(cpuPkg::ADD, 2, 3);
  memOp(cpuPkg::ST, 0, 2, ioIn);
  addOp(cpuPkg::SUB, 3, 2);
  memOp(cpuPkg::ST, 0, 3, ioIn);
  expected.push_back(vb[7:0]);
  expected.push_back(vc[7:0]);
  expected.push_back(vd[7:0]);
  expected.push_back(ve[7:0]);
  loadProgram(5'(a));
  runAndCheck();
endtask

task automatic logicShiftTest();
  int c, m, s;
  cpuPkg::wordT v;
  logic [27:0] ext;
  c = $random(seed) & 31;
  m = $random(seed) & 31;
  // Always negative since 4c stays far below bit 13
  v = ~14'(c * 4);
  newProgram();
  addOp(cpuPkg::ADDC, 1, c);
  addOp(cpuPkg::ADD, 1, 1);
  addOp(cpuPkg::ADD, 1, 1);
  addOp(cpuPkg::NOT, 1, 0);
  memOp(cpuPkg::ST, 0, 1, ioIn);
  expected.push_back(v[7:0]);
  addOp(cpuPkg::ADDC, 2, m);
  addOp(cpuPkg::CPY, 3, 1);
  addOp(cpuPkg::AND, 3, 2);
  memOp(cpuPkg::ST, 0, 3, ioIn);
  expected.push_back(8'(v & 14'(m)));
  addOp(cpuPkg::CPY, 4, 1);
  addOp(cpuPkg::OR, 4, 2);
  memOp(cpuPkg::ST, 0, 4, ioIn);
  expected.push_back(8'(v | 14'(m)));
  addOp(cpuPkg::CPY, 5, 2);
  memOp(cpuPkg::ST, 0, 5, ioIn);
  expected.push_back(8'(m));
  for (s = 0; s < 4; s++)
  begin
    addOp(cpuPkg::CPY, 10 + s, 1);
    addOp(cpuPkg::SHRA, 10 + s, s);
    memOp(cpuPkg::ST, 0, 10 + s, ioIn);
    // Sign copied into the vacated top bits
    ext = {{14{v[13]}}, v} >> s;
    expected.push_back(ext[7:0]);
  end
  // Three shifts by 3 bring the copied sign bits into the low byte
  addOp(cpuPkg::CPY, 14, 1);
  for (s = 0; s < 3; s++)
    addOp(cpuPkg::SHRA, 14, 3);
  memOp(cpuPkg::ST, 0, 14, ioIn);
  ext = {{14{v[13]}}, v} >> 9;
  expected.push_back(ext[7:0]);
  loadProgram(5'd0);
  runAndCheck();
endtask

task automatic forwardingTest();
  int k, i;
  cpuPkg::wordT total;
  total = '0;
  newProgram();
  for (i = 0; i < 6; i++)
  begin
    k = $random(seed) & 31;
    addOp(cpuPkg::ADDC, 1, k);
    total = total + 14'(k);
  end
  // B operand bypass, then A operand bypass
  addOp(cpuPkg::ADD, 2, 1);
  k = $random(seed) & 31;
  addOp(cpuPkg::ADDC, 2, k);
  memOp(cpuPkg::ST, 0, 1, ioIn);
  memOp(cpuPkg::ST, 0, 2, ioIn);
  expected.push_back(total[7:0]);
  expected.push_back(8'(total + 14'(k)));
  loadProgram(5'd0);
  runAndCheck();
endtask

task automatic jumpConditionTest();
  int i;
  newProgram();
  addOp(cpuPkg::ADDC, 1, 1);
  addOp(cpuPkg::ADDC, 2, 2);
  addOp(cpuPkg::NOT, 4, 0);
  addOp(cpuPkg::ADDC, 3, 31);
  // 31 doubled eight times is 1F00
  for (i = 0; i < 8; i++)
    addOp(cpuPkg::ADD, 3, 3);
  condBlock(cpuPkg::JU, 1'b1);
  // 3FFF + 1 sets C and Z, clears N and V
  addOp(cpuPkg::CPY, 7, 4);
  addOp(cpuPkg::ADD, 7, 1);
  condBlock(cpuPkg::JC1, 1'b1);
  condBlock(cpuPkg::JZ0, 1'b0);
  condBlock(cpuPkg::JN1, 1'b0);
  // 1F00 + 1F00 = 3E00, two positives give a negative
  addOp(cpuPkg::ADD, 3, 3);
  condBlock(cpuPkg::JV1, 1'b1);
  condBlock(cpuPkg::JC0, 1'b1);
  condBlock(cpuPkg::JN0, 1'b0);
  // 0 - 1 borrows, result negative and nonzero
  addOp(cpuPkg::SUB, 9, 1);
  condBlock(cpuPkg::JV0, 1'b1);
  condBlock(cpuPkg::JZ1, 1'b0);
  loadProgram(5'd0);
  runAndCheck();
endtask

task automatic ioWindowTest();
  int swVal;
  // Odd value, so a switch read never looks like zero
  swVal = ($random(seed) & 31) | 1;
  newProgram();
  addOp(cpuPkg::ADDC, 1, 7);
  addOp(cpuPkg::ADDC, 5, 9);
  addOp(cpuPkg::ADDC, 6, 2);
  // Both bounds are outside
  memOp(cpuPkg::ST, 0, 1, 'h3F00);
  memOp(cpuPkg::ST, 0, 1, 'h3FFF);
  memOp(cpuPkg::LD, 0, 5, 'h0100);
  memOp(cpuPkg::ST, 0, 5, ioIn);
  expected.push_back(8'd0);
  // Nonzero R0 still means no index, 3FFE + 3 would leave the window
  addOp(cpuPkg::ADDC, 0, 3);
  memOp(cpuPkg::ST, 0, 1, 'h3FFE);
  expected.push_back(8'd7);
  memOp(cpuPkg::ST, 6, 1, 'h3EFF);
  expected.push_back(8'd7);
  memOp(cpuPkg::LD, 6, 8, 'h3F00);
  memOp(cpuPkg::ST, 0, 8, ioIn);
  expected.push_back(8'(swVal));
  loadProgram(5'(swVal));
  runAndCheck();
endtask

`endif

// File: dv/pipeCpuTb.sv
`default_nettype none
`timescale 1ns/100ps

module pipeCpuTb;

  localparam int progAddrW = 10;
  localparam int romWords = 2 ** progAddrW;
  localparam int clkPeriod = 20;
  localparam int resetCycles = 8;
  localparam int cyclesPerTest = 200;
  localparam int numTests = 5;
  // Quiet time after the last expected write, catches extra writes
  localparam int drainCycles = 20;

  logic Clock_pin = 1'b0;
  logic rst;
  logic [4:0] sw;
  logic [7:0] display;
  logic displayWrite;

  int seed = 25213;
  cpuPkg::wordT prog[$];
  logic [7:0] expected[$];
  logic [7:0] seen[$];

  pipeCpu #(.progAddrW(progAddrW)) DUT (
    .Clock_pin,
    .rst,
    .sw,
    .display,
    .displayWrite
  );

  always #(clkPeriod / 2) Clock_pin = ~Clock_pin;

  // Display writes, sampled away from the rising edge
  always @(negedge Clock_pin)
  begin
    if (!rst && displayWrite)
      seen.push_back(display);
  end

  task automatic checkDisplay(input int idx, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("mismatch display[%0d]: got %h, expected %h", idx, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic checkWriteCount(input int got, input int exp);
    if (got != exp)
    begin
      $display("mismatch displayWrite count: got %h, expected %h", got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Wait for every expected write, then let the pipeline run dry
  task automatic runAndCheck();
    int i;
    while (seen.size() < expected.size())
      @(negedge Clock_pin);
    repeat (drainCycles) @(negedge Clock_pin);
    checkWriteCount(seen.size(), expected.size());
    for (i = 0; i < expected.size(); i++)
      checkDisplay(i, seen[i], expected[i]);
  endtask

  `include "cpuTests.svh"

  // Reset time counted once per test
  initial
  begin
    #((numTests * (cyclesPerTest + resetCycles)) * clkPeriod);
    $display("Run timed out before all tests finished");
    $display("Test failed");
    $fatal(1);
  end

  initial
  begin
    rst = 1'b1;
    sw = '0;
    arithmeticTest();
    logicShiftTest();
    forwardingTest();
    jumpConditionTest();
    ioWindowTest();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: pipeCpu.f
+incdir+dv
design/cpuPkg.sv
design/progRom.sv
design/fetchUnit.sv
design/regFile.sv
design/operandStage.sv
design/executeStage.sv
design/pipeCpu.sv
dv/pipeCpuTb.sv
